// ==== cpu_config.svh ====
`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define XLEN 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

// architectural integer registers, x0 included
`define REG_COUNT 32

`endif

// ==== cpu_pkg.sv ====
`include "cpu_config.svh"

package cpu_pkg;

  // operations understood by the core
  typedef enum logic [2:0] {
    op_addi,
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_lui,
    op_illegal
  } op_t;

  // word handed from fetch to decode
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] instr;
  } fetcher_output;

  // one decoded instruction waiting for execute
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    op_t              op;
    logic [4:0]       rd;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    // already sign extended or shifted up for lui
    logic [`XLEN-1:0] imm;
  } decoded_t;

  // record presented on the retire port
  typedef struct packed {
    logic [`XLEN-1:0] pc;
    logic [4:0]       rd;
    logic [`XLEN-1:0] value;
    logic             illegal;
  } retire_t;

endpackage

// ==== fetcher.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module fetcher import cpu_pkg::*; (
  input  var logic             clk,
  input  var logic             reset,
  // handshake
  input  var logic             fetcher_ready,
  output var logic             fetcher_valid,
  input  var logic             mem_valid,
  output var logic             mem_ready,
  // pc from decode, word from memory
  input  var logic [`XLEN-1:0] pc,
  input  var logic [`XLEN-1:0] mem_rdata,
  // outputs
  output     fetcher_output    out,
  output var logic             mem_instr,
  output var logic [`XLEN-1:0] mem_addr,
  output var logic [3:0]       mem_wstrb
);

  // high from the request until its mem_valid comes back
  logic pending;
  logic idle;

  assign idle = !pending && !fetcher_valid;

  // instruction reads only
  assign mem_wstrb = 4'b0000;

  // one request pulse per idle period
  always_ff @(posedge clk) begin
    if (reset) begin
      pending <= 1'b0;
      mem_ready <= 1'b0;
      mem_instr <= 1'b0;
    end else if (idle) begin
      pending <= 1'b1;
      mem_ready <= 1'b1;
      mem_instr <= 1'b1;
    end else begin
      mem_ready <= 1'b0;
      mem_instr <= 1'b0;
      if (mem_valid) begin
        pending <= 1'b0;
      end
    end
  end

  // a word that arrives while decode is busy is dropped, pc has not moved
  always_ff @(posedge clk) begin
    if (reset) begin
      fetcher_valid <= 1'b0;
    end else begin
      fetcher_valid <= mem_valid && fetcher_ready;
    end
  end

  // address and pc are latched with the request
  always_ff @(posedge clk) begin
    if (idle) begin
      mem_addr <= pc;
      out.pc <= pc;
    end
    if (mem_valid && fetcher_ready) begin
      out.instr <= mem_rdata;
    end
  end

endmodule

// ==== decoder.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module decoder import cpu_pkg::*; (
  input  var logic             clk,
  input  var logic             reset,
  // from fetch
  input  var logic             fetch_valid,
  output var logic             fetch_ready,
  input      fetcher_output    fetch,
  output var logic [`XLEN-1:0] pc,
  // to execute
  output var logic             dec_valid,
  input  var logic             dec_ready,
  output     decoded_t         dec
);

  // major opcodes of the supported subset
  localparam logic [6:0] opc_op_imm = 7'b0010011;
  localparam logic [6:0] opc_op     = 7'b0110011;
  localparam logic [6:0] opc_lui    = 7'b0110111;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       fetch_fire;
  op_t        op;
  decoded_t   next;

  assign opcode = fetch.instr[6:0];
  assign funct3 = fetch.instr[14:12];
  assign funct7 = fetch.instr[31:25];

  // register empty or execute taking it this cycle
  assign fetch_ready = !dec_valid || dec_ready;
  assign fetch_fire = fetch_valid && fetch_ready;

  always_comb begin
    op = op_illegal;
    case (opcode)
      opc_op_imm: begin
        if (funct3 == 3'b000) begin
          op = op_addi;
        end
      end
      opc_op: begin
        if (funct7 == 7'b0000000) begin
          case (funct3)
            3'b000:  op = op_add;
            3'b111:  op = op_and;
            3'b110:  op = op_or;
            3'b100:  op = op_xor;
            default: op = op_illegal;
          endcase
        end else if (funct7 == 7'b0100000 && funct3 == 3'b000) begin
          op = op_sub;
        end
      end
      opc_lui: op = op_lui;
      default: op = op_illegal;
    endcase
  end

  always_comb begin
    next.pc = fetch.pc;
    next.op = op;
    next.rd = fetch.instr[11:7];
    next.rs1 = fetch.instr[19:15];
    next.rs2 = fetch.instr[24:20];
    // u-type for lui, sign extended i-type otherwise
    if (op == op_lui) begin
      next.imm = {fetch.instr[31:12], 12'b0};
    end else begin
      next.imm = {{20{fetch.instr[31]}}, fetch.instr[31:20]};
    end
  end

  // pc only moves on an accepted word
  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
      dec_valid <= 1'b0;
    end else if (fetch_fire) begin
      pc <= pc + `XLEN'(4);
      dec_valid <= 1'b1;
    end else if (dec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fetch_fire) begin
      dec <= next;
    end
  end

endmodule

// ==== executor.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module executor import cpu_pkg::*; (
  input  var logic clk,
  input  var logic reset,
  // from decode
  input  var logic dec_valid,
  output var logic dec_ready,
  input  decoded_t dec,
  // retire port
  output var logic retire_valid,
  input  var logic retire_ready,
  output retire_t  retire
);

  logic [`XLEN-1:0] regs [`REG_COUNT];
  logic [`XLEN-1:0] rs1_val;
  logic [`XLEN-1:0] rs2_val;
  logic [`XLEN-1:0] alu;
  logic             illegal;
  logic             wr_en;
  logic             dec_fire;

  // retire slot free or being emptied this cycle
  assign dec_ready = !retire_valid || retire_ready;
  assign dec_fire = dec_valid && dec_ready;

  // x0 reads as zero
  assign rs1_val = (dec.rs1 == 5'd0) ? '0 : regs[dec.rs1];
  assign rs2_val = (dec.rs2 == 5'd0) ? '0 : regs[dec.rs2];

  assign illegal = (dec.op == op_illegal);
  assign wr_en = dec_fire && !illegal && (dec.rd != 5'd0);

  always_comb begin
    case (dec.op)
      op_addi: alu = rs1_val + dec.imm;
      op_add:  alu = rs1_val + rs2_val;
      op_sub:  alu = rs1_val - rs2_val;
      op_and:  alu = rs1_val & rs2_val;
      op_or:   alu = rs1_val | rs2_val;
      op_xor:  alu = rs1_val ^ rs2_val;
      op_lui:  alu = dec.imm;
      default: alu = '0;
    endcase
  end

  // register file, written in the same edge the retire record loads
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[dec.rd] <= alu;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      retire_valid <= 1'b0;
    end else if (dec_fire) begin
      retire_valid <= 1'b1;
    end else if (retire_ready) begin
      retire_valid <= 1'b0;
    end
  end

  // held while the consumer stalls
  always_ff @(posedge clk) begin
    if (dec_fire) begin
      retire.pc <= dec.pc;
      retire.illegal <= illegal;
      if (illegal) begin
        retire.rd <= 5'd0;
        retire.value <= '0;
      end else begin
        retire.rd <= dec.rd;
        retire.value <= alu;
      end
    end
  end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module cpu_top import cpu_pkg::*; (
  input  var logic             clk,
  input  var logic             reset,
  // instruction memory
  input  var logic             mem_valid,
  input  var logic [`XLEN-1:0] mem_rdata,
  output var logic             mem_ready,
  output var logic             mem_instr,
  output var logic [`XLEN-1:0] mem_addr,
  output var logic [3:0]       mem_wstrb,
  // retire port
  output var logic             retire_valid,
  input  var logic             retire_ready,
  output     retire_t          retire
);

  logic             fetcher_valid;
  logic             fetcher_ready;
  fetcher_output    fetch_out;
  logic [`XLEN-1:0] pc;
  logic             dec_valid;
  logic             dec_ready;
  decoded_t         dec;

  fetcher fetch0 (
    .clk           (clk),
    .reset         (reset),
    .fetcher_ready (fetcher_ready),
    .fetcher_valid (fetcher_valid),
    .mem_valid     (mem_valid),
    .mem_ready     (mem_ready),
    .pc            (pc),
    .mem_rdata     (mem_rdata),
    .out           (fetch_out),
    .mem_instr     (mem_instr),
    .mem_addr      (mem_addr),
    .mem_wstrb     (mem_wstrb)
  );

  decoder decode0 (
    .clk         (clk),
    .reset       (reset),
    .fetch_valid (fetcher_valid),
    .fetch_ready (fetcher_ready),
    .fetch       (fetch_out),
    .pc          (pc),
    .dec_valid   (dec_valid),
    .dec_ready   (dec_ready),
    .dec         (dec)
  );

  executor exec0 (
    .clk          (clk),
    .reset        (reset),
    .dec_valid    (dec_valid),
    .dec_ready    (dec_ready),
    .dec          (dec),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire)
  );

endmodule

// ==== tb_clock.sv ====
`timescale 1ns/10ps

module tb_clock (
  output logic clk,
  output logic reset
);

  // 10 ns period
  initial begin
    clk = 1'b0;
    forever begin
      #5 clk = ~clk;
    end
  end

  // held for ten rising edges, released just after the last one
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge clk);
    #1 reset = 1'b0;
  end

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/10ps
`include "cpu_config.svh"

module tb_cpu import cpu_pkg::*; ();

  localparam int prog_len = 256;
  localparam int timeout_cycles = prog_len * 40;

  logic             clk;
  logic             reset;
  logic             mem_valid;
  logic [`XLEN-1:0] mem_rdata;
  logic             mem_ready;
  logic             mem_instr;
  logic [`XLEN-1:0] mem_addr;
  logic [3:0]       mem_wstrb;
  logic             retire_valid;
  logic             retire_ready;
  retire_t          retire;

  logic [31:0] prog [prog_len];
  logic [31:0] model_regs [`REG_COUNT];
  logic [31:0] rand_state;
  logic [31:0] last_addr;
  logic        seen_request;
  int          errors;

  tb_clock clock0 (
    .clk   (clk),
    .reset (reset)
  );

  cpu_top dut0 (
    .clk          (clk),
    .reset        (reset),
    .mem_valid    (mem_valid),
    .mem_rdata    (mem_rdata),
    .mem_ready    (mem_ready),
    .mem_instr    (mem_instr),
    .mem_addr     (mem_addr),
    .mem_wstrb    (mem_wstrb),
    .retire_valid (retire_valid),
    .retire_ready (retire_ready),
    .retire       (retire)
  );

  function automatic logic [31:0] next_rand();
    rand_state = rand_state * 32'd1664525 + 32'd1013904223;
    return rand_state;
  endfunction

  // mostly subset encodings on x0..x7 so results feed each other
  function automatic logic [31:0] make_word();
    logic [31:0] pick;
    logic [31:0] bits;
    logic [31:0] word;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    pick = next_rand();
    bits = next_rand();
    rd = {2'b00, bits[31:29]};
    rs1 = {2'b00, bits[28:26]};
    rs2 = {2'b00, bits[25:23]};
    case (pick[15:13])
      3'd1:    word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
      3'd2:    word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
      3'd3:    word = {7'b0000000, rs2, rs1, 3'b111, rd, 7'b0110011};
      3'd4:    word = {7'b0000000, rs2, rs1, 3'b110, rd, 7'b0110011};
      3'd5:    word = {7'b0000000, rs2, rs1, 3'b100, rd, 7'b0110011};
      3'd6:    word = {bits[22:3], rd, 7'b0110111};
      default: word = {bits[22:11], rs1, 3'b000, rd, 7'b0010011};
    endcase
    // about one word in ten is left fully random
    if (pick[31:16] % 16'd10 == 16'd9) begin
      word = bits;
    end
    return word;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    errors++;
    $display("[ERROR] %s at %0t: expected %h, actual %h", name, $time, expected, actual);
  endtask

  task automatic report_problem(input string what);
    errors++;
    $display("[ERROR] at %0t: %s", $time, what);
  endtask

  // architectural result of one word, straight from the instruction encoding
  task automatic model_step(input logic [31:0] word, input logic [31:0] pc,
                            output retire_t expected);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] result;
    logic [4:0]  rd;
    logic        legal;
    a = model_regs[word[19:15]];
    b = model_regs[word[24:20]];
    rd = word[11:7];
    legal = 1'b1;
    casez ({word[31:25], word[14:12], word[6:0]})
      17'b???????_000_0010011: result = a + {{20{word[31]}}, word[31:20]};
      17'b0000000_000_0110011: result = a + b;
      17'b0100000_000_0110011: result = a - b;
      17'b0000000_111_0110011: result = a & b;
      17'b0000000_110_0110011: result = a | b;
      17'b0000000_100_0110011: result = a ^ b;
      17'b???????_???_0110111: result = {word[31:12], 12'h000};
      default: begin
        legal = 1'b0;
        result = 32'd0;
      end
    endcase
    // x0 is never written, so it keeps reading zero
    if (legal && rd != 5'd0) begin
      model_regs[rd] = result;
    end
    expected.pc = pc;
    expected.rd = legal ? rd : 5'd0;
    expected.value = result;
    expected.illegal = !legal;
  endtask

  task automatic check_request();
    assert (mem_wstrb == 4'b0000)
      else report_mismatch("mem_wstrb", 32'd0, {28'd0, mem_wstrb});
    assert (mem_instr) else report_problem("read request without mem_instr");
    if (!seen_request) begin
      assert (mem_addr == `RESET_PC)
        else report_mismatch("first fetch address", `RESET_PC, mem_addr);
    end else begin
      assert (mem_addr == last_addr || mem_addr == last_addr + 32'd4)
        else report_problem("fetch address neither repeats nor steps by 4");
    end
    seen_request = 1'b1;
    last_addr = mem_addr;
  endtask

  task automatic check_retire(input retire_t expected);
    assert (retire.pc == expected.pc) else report_mismatch("retire pc", expected.pc, retire.pc);
    assert (retire.rd == expected.rd)
      else report_mismatch("retire rd", {27'd0, expected.rd}, {27'd0, retire.rd});
    assert (retire.value == expected.value)
      else report_mismatch("retire value", expected.value, retire.value);
    assert (retire.illegal == expected.illegal)
      else report_mismatch("retire illegal", {31'd0, expected.illegal}, {31'd0, retire.illegal});
  endtask

  initial begin
    retire_t     expected;
    retire_t     prev_retire;
    logic        prev_stall;
    logic        req_pending;
    logic [2:0]  req_wait;
    logic [31:0] req_addr;
    logic [31:0] bits;
    int          retired;
    int          cycles;
    mem_valid = 1'b0;
    mem_rdata = '0;
    retire_ready = 1'b0;
    rand_state = 32'h0204_5fbf;
    errors = 0;
    retired = 0;
    cycles = 0;
    seen_request = 1'b0;
    last_addr = '0;
    prev_stall = 1'b0;
    prev_retire = '0;
    req_pending = 1'b0;
    req_wait = 3'd0;
    req_addr = '0;
    for (int i = 0; i < prog_len; i++) begin
      prog[i[7:0]] = make_word();
    end
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i[4:0]] = '0;
    end
    @(negedge reset);

    while (retired < prog_len && cycles < timeout_cycles) begin
      @(posedge clk);
      #1;
      cycles++;
      // a stalled record must be presented again unchanged
      if (prev_stall) begin
        assert (retire_valid) else report_problem("retire_valid dropped while stalled");
        assert (retire == prev_retire) else report_problem("retire record changed while stalled");
      end
      // memory responder, one response per request after 1 to 4 cycles
      mem_valid = 1'b0;
      if (req_pending) begin
        req_wait = req_wait - 3'd1;
        if (req_wait == 3'd0) begin
          mem_valid = 1'b1;
          mem_rdata = prog[req_addr[9:2]];
          req_pending = 1'b0;
        end
      end
      if (mem_ready) begin
        assert (!req_pending) else report_problem("new fetch issued while a read was outstanding");
        check_request();
        bits = next_rand();
        req_addr = mem_addr;
        req_wait = {1'b0, bits[31:30]} + 3'd1;
        req_pending = 1'b1;
      end
      // random back-pressure on the retire port
      bits = next_rand();
      retire_ready = (bits[31:30] != 2'b00);
      if (retire_valid && retire_ready) begin
        model_step(prog[retired[7:0]], 32'(retired * 4), expected);
        check_retire(expected);
        retired++;
      end
      prev_stall = retire_valid && !retire_ready;
      prev_retire = retire;
    end

    if (retired < prog_len) begin
      $display("timeout: %0d of %0d instructions retired in %0d cycles",
               retired, prog_len, cycles);
    end
    $display("retired %0d instructions in %0d cycles with %0d errors", retired, cycles, errors);
    if (errors == 0 && retired == prog_len) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
+incdir+.
cpu_pkg.sv
fetcher.sv
decoder.sv
executor.sv
cpu_top.sv
tb_clock.sv
tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f flist.f --top-module tb_cpu -o tb_cpu_sim
output=$(./obj_dir/tb_cpu_sim)
echo "$output"
if echo "$output" | grep -q "^Result: PASSED$"; then
  exit 0
else
  exit 1
fi
